//--- Makefile
TOP := ethRxPathTb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f all.f

# The run passes only if the pass message shows up in the output
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

//--- all.f
design/ethPkg.sv
design/rxPkg.sv
design/ethCrc.sv
design/rxNibbleFramer.sv
design/rxEntryFifo.sv
design/rxFrameReporter.sv
design/ethRxPath.sv
dv/ethRxPathChecker.sv
dv/ethRxPathTb.sv

//--- design/ethCrc.sv
`timescale 1ns/1ps

module ethCrc
  import ethPkg::*;
(
  input  logic   Clk,
  input  logic   Reset,
  input  nibbleT Data,
  input  logic   Enable,
  input  logic   Initialize,
  output crcT    Crc,
  output logic   CrcError
);

  nibbleT fb;
  crcT    crcNext;

  // Feedback terms, one per input bit, against the top nibble of the register
  assign fb = {4{Enable}} & (Data ^ Crc[31:28]);

  always_comb
  begin
    crcNext[0]  = fb[0];
    crcNext[1]  = fb[1] ^ fb[0];
    crcNext[2]  = fb[2] ^ fb[1] ^ fb[0];
    crcNext[3]  = fb[3] ^ fb[2] ^ fb[1];
    crcNext[4]  = fb[3] ^ fb[2] ^ fb[0] ^ Crc[0];
    crcNext[5]  = fb[3] ^ fb[1] ^ fb[0] ^ Crc[1];
    crcNext[6]  = fb[2] ^ fb[1] ^ Crc[2];
    crcNext[7]  = fb[3] ^ fb[2] ^ fb[0] ^ Crc[3];
    crcNext[8]  = fb[3] ^ fb[1] ^ fb[0] ^ Crc[4];
    crcNext[9]  = fb[2] ^ fb[1] ^ Crc[5];
    crcNext[10] = fb[3] ^ fb[2] ^ fb[0] ^ Crc[6];
    crcNext[11] = fb[3] ^ fb[1] ^ fb[0] ^ Crc[7];
    crcNext[12] = fb[2] ^ fb[1] ^ fb[0] ^ Crc[8];
    crcNext[13] = fb[3] ^ fb[2] ^ fb[1] ^ Crc[9];
    crcNext[14] = fb[3] ^ fb[2] ^ Crc[10];
    crcNext[15] = fb[3] ^ Crc[11];
    crcNext[16] = fb[0] ^ Crc[12];
    crcNext[17] = fb[1] ^ Crc[13];
    crcNext[18] = fb[2] ^ Crc[14];
    crcNext[19] = fb[3] ^ Crc[15];
    crcNext[20] = Crc[16];
    crcNext[21] = Crc[17];
    crcNext[22] = fb[0] ^ Crc[18];
    crcNext[23] = fb[1] ^ fb[0] ^ Crc[19];
    crcNext[24] = fb[2] ^ fb[1] ^ Crc[20];
    crcNext[25] = fb[3] ^ fb[2] ^ Crc[21];
    crcNext[26] = fb[3] ^ fb[0] ^ Crc[22];
    crcNext[27] = fb[1] ^ Crc[23];
    crcNext[28] = fb[2] ^ Crc[24];
    crcNext[29] = fb[3] ^ Crc[25];
    crcNext[30] = Crc[26];
    crcNext[31] = Crc[27];
  end

  always_ff @(posedge Clk or posedge Reset)
  begin
    if (Reset)
      Crc <= CrcSeed;
    else if (Initialize)
      Crc <= CrcSeed;
    else
      Crc <= crcNext;
  end

  assign CrcError = (Crc != CrcResidue);

endmodule

//--- design/ethPkg.sv
package ethPkg;

  // One MII transfer, four bits wide
  typedef logic [3:0] nibbleT;

  typedef logic [7:0] byteT;

  typedef logic [31:0] crcT;

  // Byte count of a frame with its FCS included
  typedef logic [10:0] frameLenT;

  // Every preamble nibble reads 5 on the MII
  localparam nibbleT PreambleNibble = 4'h5;

  // High nibble of the start-of-frame delimiter, which ends the preamble
  localparam nibbleT SfdNibble = 4'hd;

  localparam crcT CrcSeed = 32'hffff_ffff;

  // What remains in the register once a good frame and its FCS have
  // been shifted through
  localparam crcT CrcResidue = 32'hc704_dd7b;

endpackage

//--- design/ethRxPath.sv
`timescale 1ns/1ps

module ethRxPath
  import ethPkg::*, rxPkg::*;
(
  input  logic        Clk,
  input  logic        Reset,
  input  logic        RxDv,
  input  nibbleT      RxData,
  output byteT        RxByte,
  output logic        RxByteValid,
  output frameStatusT FrameStatus,
  output logic        FrameDone
);

  nibbleT    crcData;
  logic      crcEnable;
  logic      crcInit;
  logic      crcError;
  logic      fifoWrite;
  fifoEntryT fifoWrData;
  logic      fifoRead;
  fifoEntryT fifoRdData;
  logic      fifoEmpty;

  rxNibbleFramer rxNibbleFramer_i (
    .Clk        (Clk),
    .Reset      (Reset),
    .RxDv       (RxDv),
    .RxData     (RxData),
    .CrcError   (crcError),
    .CrcData    (crcData),
    .CrcEnable  (crcEnable),
    .CrcInit    (crcInit),
    .FifoWrite  (fifoWrite),
    .FifoWrData (fifoWrData)
  );

  ethCrc ethCrc_i (
    .Clk        (Clk),
    .Reset      (Reset),
    .Data       (crcData),
    .Enable     (crcEnable),
    .Initialize (crcInit),
    .Crc        (),
    .CrcError   (crcError)
  );

  // Full is left for the bound checker
  rxEntryFifo rxEntryFifo_i (
    .Clk    (Clk),
    .Reset  (Reset),
    .Write  (fifoWrite),
    .WrData (fifoWrData),
    .Read   (fifoRead),
    .RdData (fifoRdData),
    .Empty  (fifoEmpty),
    .Full   ()
  );

  rxFrameReporter rxFrameReporter_i (
    .Clk         (Clk),
    .Reset       (Reset),
    .FifoEmpty   (fifoEmpty),
    .FifoRdData  (fifoRdData),
    .FifoRead    (fifoRead),
    .RxByte      (RxByte),
    .RxByteValid (RxByteValid),
    .FrameStatus (FrameStatus),
    .FrameDone   (FrameDone)
  );

endmodule

//--- design/rxEntryFifo.sv
`timescale 1ns/1ps

module rxEntryFifo
  import rxPkg::*;
(
  input  logic      Clk,
  input  logic      Reset,
  input  logic      Write,
  input  fifoEntryT WrData,
  input  logic      Read,
  output fifoEntryT RdData,
  output logic      Empty,
  output logic      Full
);

  fifoEntryT mem [FifoDepth];

  logic [$clog2(FifoDepth)-1:0] wrPtr;
  logic [$clog2(FifoDepth)-1:0] rdPtr;
  logic [$clog2(FifoDepth):0]   count;

  assign Empty = (count == 0);
  assign Full  = (count == FifoDepth);

  always_ff @(posedge Clk or posedge Reset)
  begin
    if (Reset)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (Write)
        wrPtr <= wrPtr + 1'b1;
      if (Read)
        rdPtr <= rdPtr + 1'b1;
      // Both at once leaves the count alone
      if (Write && !Read)
        count <= count + 1'b1;
      else if (Read && !Write)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge Clk)
  begin
    if (Write)
      mem[wrPtr] <= WrData;
    if (Read)
      RdData <= mem[rdPtr];
  end

endmodule

//--- design/rxFrameReporter.sv
`timescale 1ns/1ps

module rxFrameReporter
  import ethPkg::*, rxPkg::*;
(
  input  logic        Clk,
  input  logic        Reset,
  input  logic        FifoEmpty,
  input  fifoEntryT   FifoRdData,
  output logic        FifoRead,
  output byteT        RxByte,
  output logic        RxByteValid,
  output frameStatusT FrameStatus,
  output logic        FrameDone
);

  // Set for the cycle in which the FIFO presents the entry just read
  logic     readPending;
  frameLenT byteCount;

  assign FifoRead = !FifoEmpty;

  always_ff @(posedge Clk or posedge Reset)
  begin
    if (Reset)
    begin
      readPending <= 1'b0;
      RxByteValid <= 1'b0;
      FrameDone   <= 1'b0;
      byteCount   <= '0;
    end
    else
    begin
      readPending <= FifoRead;
      RxByteValid <= readPending && !FifoRdData.isEnd;
      FrameDone   <= readPending && FifoRdData.isEnd;
      if (readPending)
      begin
        if (FifoRdData.isEnd)
          byteCount <= '0;
        else
          byteCount <= byteCount + 1'b1;
      end
    end
  end

  always_ff @(posedge Clk)
  begin
    if (readPending)
    begin
      if (FifoRdData.isEnd)
      begin
        FrameStatus.length <= byteCount;
        FrameStatus.crcOk  <= FifoRdData.payload[0];
      end
      else
        RxByte <= FifoRdData.payload;
    end
  end

endmodule

//--- design/rxNibbleFramer.sv
`timescale 1ns/1ps

module rxNibbleFramer
  import ethPkg::*, rxPkg::*;
(
  input  logic      Clk,
  input  logic      Reset,
  input  logic      RxDv,
  input  nibbleT    RxData,
  input  logic      CrcError,
  output nibbleT    CrcData,
  output logic      CrcEnable,
  output logic      CrcInit,
  output logic      FifoWrite,
  output fifoEntryT FifoWrData
);

  typedef enum logic [1:0] {
    StIdle,
    StPreamble,
    StData
  } stateT;

  stateT  state;
  nibbleT lowNibble;
  // High once the low nibble of a byte has been taken, so also the nibble parity
  logic   highPhase;
  logic   crcOk;

  // The CRC block expects each nibble with its bit order reversed
  assign CrcData   = {RxData[0], RxData[1], RxData[2], RxData[3]};
  assign CrcEnable = (state == StData) && RxDv;
  assign CrcInit   = (state != StData);

  // An odd nibble count can never pass, whatever the CRC says
  assign crcOk = !CrcError && !highPhase;

  always_ff @(posedge Clk or posedge Reset)
  begin
    if (Reset)
    begin
      state     <= StIdle;
      highPhase <= 1'b0;
      FifoWrite <= 1'b0;
    end
    else
    begin
      FifoWrite <= 1'b0;
      case (state)
        StIdle:
          if (RxDv && RxData == PreambleNibble)
            state <= StPreamble;
        StPreamble:
          if (!RxDv)
            state <= StIdle;
          else if (RxData == SfdNibble)
          begin
            state     <= StData;
            highPhase <= 1'b0;
          end
          else if (RxData != PreambleNibble)
            state <= StIdle;
        StData:
          if (RxDv)
          begin
            highPhase <= !highPhase;
            FifoWrite <= highPhase;
          end
          else
          begin
            // Frame is over, so the end marker goes out
            FifoWrite <= 1'b1;
            state     <= StIdle;
          end
        default:
          state <= StIdle;
      endcase
    end
  end

  always_ff @(posedge Clk)
  begin
    if (state == StData)
    begin
      if (RxDv && !highPhase)
        lowNibble <= RxData;
      else if (RxDv)
      begin
        FifoWrData.isEnd   <= 1'b0;
        FifoWrData.payload <= {RxData, lowNibble};
      end
      else
      begin
        FifoWrData.isEnd   <= 1'b1;
        FifoWrData.payload <= {7'd0, crcOk};
      end
    end
  end

endmodule

//--- design/rxPkg.sv
package rxPkg;

  import ethPkg::*;

  // An entry is either a data byte or the marker that closes a frame.
  // In the marker, payload bit 0 carries the CRC verdict
  typedef struct packed {
    logic isEnd;
    byteT payload;
  } fifoEntryT;

  typedef struct packed {
    frameLenT length;
    logic     crcOk;
  } frameStatusT;

  // Writes come at most every other cycle and reads drain every cycle,
  // so this is generous
  localparam int FifoDepth = 16;

endpackage

//--- dv/ethRxPathChecker.sv
`timescale 1ns/1ps

module ethRxPathChecker
(
  input logic Clk,
  input logic Reset,
  input logic Write,
  input logic Read,
  input logic Empty,
  input logic Full
);

  int failCount = 0;

  // The framer never outruns the reporter, so the FIFO must never fill up
  writeWhileFull: assert property (@(posedge Clk) disable iff (Reset) !(Write && Full))
    else
    begin
      failCount++;
      $error("FIFO written while full");
    end

  readWhileEmpty: assert property (@(posedge Clk) disable iff (Reset) !(Read && Empty))
    else
    begin
      failCount++;
      $error("FIFO read while empty");
    end

endmodule

//--- dv/ethRxPathTb.sv
`timescale 1ns/1ps

module ethRxPathTb
  import ethPkg::*, rxPkg::*;
();

  localparam int ClkPeriod = 4;
  localparam int RandomFrames = 40;
  localparam int BurstFrames = 8;
  // The longest frame has 15 preamble nibbles, the delimiter, 64 bytes,
  // a dribble nibble and 6 idle cycles
  localparam int MaxFrameCycles = 15 + 1 + 2 * 64 + 1 + 6;
  localparam int TimeoutCycles = 2 * ((RandomFrames + BurstFrames) * MaxFrameCycles + 10) + 100;

  logic        Clk = 1'b0;
  logic        Reset;
  logic        RxDv;
  nibbleT      RxData;
  byteT        RxByte;
  logic        RxByteValid;
  frameStatusT FrameStatus;
  logic        FrameDone;

  byteT        expectedBytes[$];
  frameStatusT expectedStatus[$];
  int unsigned lcgState = 81;
  logic        frameStarted = 1'b0;
  int          valueErrors = 0;
  int          missingErrors = 0;
  int          extraErrors = 0;
  int          timeoutErrors = 0;

  ethRxPath ethRxPath_i (
    .Clk         (Clk),
    .Reset       (Reset),
    .RxDv        (RxDv),
    .RxData      (RxData),
    .RxByte      (RxByte),
    .RxByteValid (RxByteValid),
    .FrameStatus (FrameStatus),
    .FrameDone   (FrameDone)
  );

  bind rxEntryFifo ethRxPathChecker fifoChecker_i (
    .Clk   (Clk),
    .Reset (Reset),
    .Write (Write),
    .Read  (Read),
    .Empty (Empty),
    .Full  (Full)
  );

  always #(ClkPeriod / 2) Clk = ~Clk;

  function automatic int unsigned randomInRange(input int unsigned lo, input int unsigned hi);
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lo + ((lcgState >> 16) % (hi - lo + 1));
  endfunction

  // Reflected CRC-32 over the bytes, returned already complemented as the FCS
  function automatic crcT fcsOfBytes(input byteT bytes[$]);
    crcT c;
    c = 32'hffff_ffff;
    foreach (bytes[i])
    begin
      for (int b = 0; b < 8; b++)
      begin
        if (c[0] ^ bytes[i][b])
          c = (c >> 1) ^ 32'hedb8_8320;
        else
          c = c >> 1;
      end
    end
    return ~c;
  endfunction

  task automatic driveNibble(input logic dv, input nibbleT data);
    @(posedge Clk);
    #1;
    RxDv = dv;
    RxData = data;
  endtask

  task automatic sendFrame(input int payloadLen, input int preambleLen, input int gap,
                           input bit corrupt, input bit dribble);
    byteT        frameBytes[$];
    nibbleT      nibbles[$];
    crcT         fcs;
    int          idx;
    frameStatusT status;
    for (int i = 0; i < payloadLen; i++)
      frameBytes.push_back(byteT'(randomInRange(0, 255)));
    fcs = fcsOfBytes(frameBytes);
    // FCS goes out least significant byte first
    for (int i = 0; i < 4; i++)
      frameBytes.push_back(fcs[8*i +: 8]);
    foreach (frameBytes[i])
    begin
      nibbles.push_back(frameBytes[i][3:0]);
      nibbles.push_back(frameBytes[i][7:4]);
    end
    if (corrupt)
    begin
      idx = int'(randomInRange(0, nibbles.size() - 1));
      nibbles[idx] = nibbles[idx] ^ nibbleT'(randomInRange(1, 15));
    end
    for (int i = 0; i < frameBytes.size(); i++)
      expectedBytes.push_back({nibbles[2*i+1], nibbles[2*i]});
    if (dribble)
      nibbles.push_back(nibbleT'(randomInRange(0, 15)));
    status.length = frameLenT'(frameBytes.size());
    status.crcOk = !corrupt && !dribble;
    expectedStatus.push_back(status);
    repeat (preambleLen) driveNibble(1'b1, 4'h5);
    driveNibble(1'b1, 4'hd);
    foreach (nibbles[i])
      driveNibble(1'b1, nibbles[i]);
    repeat (gap) driveNibble(1'b0, 4'h0);
  endtask

  task automatic checkByte();
    byteT expected;
    assert (expectedBytes.size() != 0)
    else
    begin
      extraErrors++;
      $display("Unexpected RxByteValid at %0t when no byte was expected", $time);
    end
    if (expectedBytes.size() != 0)
    begin
      expected = expectedBytes.pop_front();
      assert (RxByte === expected)
      else
      begin
        valueErrors++;
        $display("Fail at %0t: RxByte expected %h, got %h", $time, expected, RxByte);
      end
    end
  endtask

  task automatic checkStatus();
    frameStatusT expected;
    assert (expectedStatus.size() != 0)
    else
    begin
      extraErrors++;
      $display("Unexpected FrameDone at %0t when no frame was pending", $time);
    end
    if (expectedStatus.size() != 0)
    begin
      expected = expectedStatus.pop_front();
      assert (FrameStatus === expected)
      else
      begin
        valueErrors++;
        $display(
          "Fail at %0t: FrameStatus expected length %0d crcOk %0b, got length %0d crcOk %0b",
          $time, expected.length, expected.crcOk, FrameStatus.length, FrameStatus.crcOk);
      end
    end
  endtask

  task automatic finishRun();
    int assertionErrors;
    assertionErrors = ethRxPath_i.rxEntryFifo_i.fifoChecker_i.failCount;
    $display("Errors: value %0d, missing %0d, extra %0d, timeout %0d, assertion %0d",
             valueErrors, missingErrors, extraErrors, timeoutErrors, assertionErrors);
    if (valueErrors + missingErrors + extraErrors + timeoutErrors + assertionErrors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  endtask

  // Outputs settle after the rising edge, so they are read on the falling one
  always @(negedge Clk)
  begin
    if (!frameStarted)
    begin
      assert (!RxByteValid && !FrameDone)
      else
      begin
        extraErrors++;
        $display("Output strobe seen at %0t before any frame was sent", $time);
      end
    end
    else
    begin
      if (RxByteValid)
        checkByte();
      if (FrameDone)
        checkStatus();
    end
  end

  initial
  begin
    #(TimeoutCycles * ClkPeriod);
    timeoutErrors++;
    $display("Timeout after %0d cycles with %0d frames still outstanding",
             TimeoutCycles, expectedStatus.size());
    finishRun();
  end

  initial
  begin
    int  preambleLen;
    bit  corrupt;
    bit  dribble;
    Reset = 1'b1;
    RxDv = 1'b0;
    RxData = 4'h0;
    repeat (5) @(posedge Clk);
    #1;
    Reset = 1'b0;
    repeat (10) driveNibble(1'b0, 4'h0);
    frameStarted = 1'b1;
    for (int i = 0; i < RandomFrames; i++)
    begin
      preambleLen = int'(randomInRange(1, 15));
      corrupt = (randomInRange(0, 3) == 0);
      dribble = (randomInRange(0, 4) == 0);
      // Start with the shortest preamble on a clean frame
      if (i == 0)
      begin
        preambleLen = 1;
        corrupt = 1'b0;
        dribble = 1'b0;
      end
      sendFrame(int'(randomInRange(1, 60)), preambleLen, int'(randomInRange(2, 6)),
                corrupt, dribble);
    end
    for (int i = 0; i < BurstFrames; i++)
      sendFrame(int'(randomInRange(1, 8)), int'(randomInRange(1, 15)), 2, 1'b0, 1'b0);
    while (expectedStatus.size() != 0)
      @(negedge Clk);
    assert (expectedBytes.size() == 0)
    else
    begin
      missingErrors += expectedBytes.size();
      $display("%0d expected bytes never came out", expectedBytes.size());
    end
    finishRun();
  end

endmodule
